// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_keypad_entry
FILELIST := keypad_entry.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No result in log"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// File: keypad_entry.f
+incdir+tb
src/bus_pkg.sv
src/keypad_pkg.sv
src/axil_if.sv
src/keypad_scanner.sv
src/multitap_decoder.sv
src/buffer_arbiter.sv
src/word_buffer.sv
src/keypad_entry_top.sv
tb/tb_keypad_entry.sv

// File: src/axil_if.sv
`timescale 1ns/100ps

interface axil_if;
  import bus_pkg::*;

  logic [AXIL_ADDR_W-1:0] awaddr; // Write address
  logic                   awvalid;
  logic                   awready;
  logic [AXIL_DATA_W-1:0] wdata; // Write data, lane 0 only used
  logic                   wvalid;
  logic                   wready;
  resp_t                  bresp; // Write response
  logic                   bvalid;
  logic                   bready;
  logic [AXIL_ADDR_W-1:0] araddr; // Read address
  logic                   arvalid;
  logic                   arready;
  logic [AXIL_DATA_W-1:0] rdata; // Read data
  resp_t                  rresp;
  logic                   rvalid;
  logic                   rready;

  modport master (
    output awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

// File: src/buffer_arbiter.sv
`timescale 1ns/100ps

module buffer_arbiter (
  input  logic   clk,
  input  logic   nRst,
  axil_if.slave  m0,
  axil_if.slave  m1,
  axil_if.master s
);

  logic gnt0, gnt1;
  logic last1; // Master 1 had the last grant
  logic busy;
  logic req0, req1;
  logic done; // Response handshake ends the transaction

  assign req0 = m0.awvalid | m0.arvalid;
  assign req1 = m1.awvalid | m1.arvalid;
  assign busy = gnt0 | gnt1;
  assign done = (s.bvalid & s.bready) | (s.rvalid & s.rready);

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      gnt0  <= 1'b0;
      gnt1  <= 1'b0;
      last1 <= 1'b0;
    end else if (busy) begin
      if (done) begin
        gnt0 <= 1'b0;
        gnt1 <= 1'b0;
      end
    end else if (req0 && (!req1 || last1)) begin
      gnt0  <= 1'b1;
      last1 <= 1'b0;
    end else if (req1) begin
      gnt1  <= 1'b1;
      last1 <= 1'b1;
    end
  end

  // Request side, granted master only
  assign s.awaddr  = gnt1 ? m1.awaddr : m0.awaddr;
  assign s.awvalid = (gnt0 & m0.awvalid) | (gnt1 & m1.awvalid);
  assign s.wdata   = gnt1 ? m1.wdata : m0.wdata;
  assign s.wvalid  = (gnt0 & m0.wvalid) | (gnt1 & m1.wvalid);
  assign s.bready  = (gnt0 & m0.bready) | (gnt1 & m1.bready);
  assign s.araddr  = gnt1 ? m1.araddr : m0.araddr;
  assign s.arvalid = (gnt0 & m0.arvalid) | (gnt1 & m1.arvalid);
  assign s.rready  = (gnt0 & m0.rready) | (gnt1 & m1.rready);

  // Response side, payload shared, handshakes gated
  assign m0.awready = gnt0 & s.awready;
  assign m0.wready  = gnt0 & s.wready;
  assign m0.bresp   = s.bresp;
  assign m0.bvalid  = gnt0 & s.bvalid;
  assign m0.arready = gnt0 & s.arready;
  assign m0.rdata   = s.rdata;
  assign m0.rresp   = s.rresp;
  assign m0.rvalid  = gnt0 & s.rvalid;
  assign m1.awready = gnt1 & s.awready;
  assign m1.wready  = gnt1 & s.wready;
  assign m1.bresp   = s.bresp;
  assign m1.bvalid  = gnt1 & s.bvalid;
  assign m1.arready = gnt1 & s.arready;
  assign m1.rdata   = s.rdata;
  assign m1.rresp   = s.rresp;
  assign m1.rvalid  = gnt1 & s.rvalid;

  a_one_grant: assert property (@(posedge clk) disable iff (!nRst)
    !(gnt0 && gnt1))
    else $error("Both masters granted");

endmodule

// File: src/bus_pkg.sv
package bus_pkg;

  // AXI4-Lite widths
  localparam int AXIL_ADDR_W = 6;
  localparam int AXIL_DATA_W = 32;

  // Word buffer size in characters
  localparam int BUF_DEPTH = 16;

  // Buffer index, one per 32-bit word
  typedef logic [3:0] ptr_t;

  // Response code
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY = 2'b00;

endpackage

// File: src/keypad_entry_top.sv
`timescale 1ns/100ps

module keypad_entry_top (
  input  logic                            clk,
  input  logic                            nRst,
  input  logic [3:0]                      row,
  output logic [3:0]                      scan_col,
  output logic [7:0]                      cur_char,
  output logic                            word_done,
  output logic                            game_end,
  // Host AXI4-Lite
  input  logic [bus_pkg::AXIL_ADDR_W-1:0] awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [bus_pkg::AXIL_DATA_W-1:0] wdata,
  input  logic                            wvalid,
  output logic                            wready,
  output bus_pkg::resp_t                  bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [bus_pkg::AXIL_ADDR_W-1:0] araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [bus_pkg::AXIL_DATA_W-1:0] rdata,
  output bus_pkg::resp_t                  rresp,
  output logic                            rvalid,
  input  logic                            rready
);
  import keypad_pkg::*;

  key_code_t key;
  logic      strobe;

  axil_if host_bus ();
  axil_if dec_bus ();
  axil_if mem_bus ();

  // Host pins onto host_bus
  assign host_bus.awaddr  = awaddr;
  assign host_bus.awvalid = awvalid;
  assign awready          = host_bus.awready;
  assign host_bus.wdata   = wdata;
  assign host_bus.wvalid  = wvalid;
  assign wready           = host_bus.wready;
  assign bresp            = host_bus.bresp;
  assign bvalid           = host_bus.bvalid;
  assign host_bus.bready  = bready;
  assign host_bus.araddr  = araddr;
  assign host_bus.arvalid = arvalid;
  assign arready          = host_bus.arready;
  assign rdata            = host_bus.rdata;
  assign rresp            = host_bus.rresp;
  assign rvalid           = host_bus.rvalid;
  assign host_bus.rready  = rready;

  keypad_scanner i_scanner (.clk(clk), .nRst(nRst), .row(row), .scan_col(scan_col),
                            .key(key), .strobe(strobe));

  multitap_decoder i_decoder (.clk(clk), .nRst(nRst), .key(key), .strobe(strobe),
                              .cur_char(cur_char), .word_done(word_done),
                              .game_end(game_end), .bus(dec_bus.master));

  // Decoder is m0, host is m1
  buffer_arbiter i_arbiter (.clk(clk), .nRst(nRst), .m0(dec_bus.slave),
                            .m1(host_bus.slave), .s(mem_bus.master));

  word_buffer i_buffer (.clk(clk), .nRst(nRst), .bus(mem_bus.slave));

endmodule

// File: src/keypad_pkg.sv
package keypad_pkg;

  // {one-hot row, one-hot active column}, bit 3 of each nibble is row/col 0
  typedef logic [7:0] key_code_t;

  // Multi-tap position, IDLE means no letter being built
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    TAP0 = 3'd1,
    TAP1 = 3'd2,
    TAP2 = 3'd3,
    TAP3 = 3'd4
  } tap_state_t;

  // Clocks per column step, small for short sims
  localparam logic [5:0] SCAN_DIV = 6'd8;

  // Action keys
  localparam key_code_t submit_letter_key = 8'b0001_1000; // R3 C0
  localparam key_code_t clear_key         = 8'b0001_0100; // R3 C1
  localparam key_code_t submit_word_key   = 8'b0001_0010; // R3 C2
  localparam key_code_t game_end_key      = 8'b0010_0001; // R2 C3

  // Four-letter keys
  localparam key_code_t key_7 = 8'b0010_1000; // R2 C0, PQRS
  localparam key_code_t key_9 = 8'b0010_0010; // R2 C2, WXYZ

  // First letter of each letter key, zero for anything else
  function automatic logic [7:0] letter_base(input key_code_t k);
    case (k)
      8'b1000_0100: letter_base = "A"; // key 2
      8'b1000_0010: letter_base = "D"; // key 3
      8'b0100_1000: letter_base = "G"; // key 4
      8'b0100_0100: letter_base = "J"; // key 5
      8'b0100_0010: letter_base = "M"; // key 6
      key_7:        letter_base = "P";
      8'b0010_0100: letter_base = "T"; // key 8
      key_9:        letter_base = "W";
      default:      letter_base = 8'd0; // 1, A, B, C, D, *, 0, #
    endcase
  endfunction

  function automatic logic four_letter(input key_code_t k);
    four_letter = (k == key_7) || (k == key_9);
  endfunction

endpackage

// File: src/keypad_scanner.sv
`timescale 1ns/100ps

module keypad_scanner (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic [3:0]            row,
  output logic [3:0]            scan_col,
  output keypad_pkg::key_code_t key,
  output logic                  strobe
);
  import keypad_pkg::*;

  logic [5:0] tick_cnt;
  logic       tick;
  logic [3:0] row_q0, row_q1, row_q1_d; // Sync stages plus edge reg

  assign tick = (tick_cnt == SCAN_DIV - 6'd1);

  // Scan tick
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst)
      tick_cnt <= '0;
    else if (tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 6'd1;
  end

  // Row synchroniser and column ring
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      row_q0   <= '0;
      row_q1   <= '0;
      row_q1_d <= '0;
      scan_col <= 4'b1111; // No column driven yet
    end else begin
      row_q0   <= row;
      row_q1   <= row_q0;
      row_q1_d <= row_q1;
      // Hold column while a key is down
      if (tick && !(|row)) begin
        case (scan_col)
          4'b0111: scan_col <= 4'b1011;
          4'b1011: scan_col <= 4'b1101;
          4'b1101: scan_col <= 4'b1110;
          default: scan_col <= 4'b0111; // From 1110 or reset
        endcase
      end
    end
  end

  // Rising edge on any synced row
  assign strobe = |(row_q1 & ~row_q1_d);

  // Row plus active column, zero when either is empty
  assign key = (|row_q1 && |(~scan_col)) ? {row_q1, ~scan_col} : 8'd0;

  a_one_col: assert property (@(posedge clk) disable iff (!nRst)
    $countones(~scan_col) <= 1)
    else $error("scan_col drives more than one column: %h", scan_col);

endmodule

// File: src/multitap_decoder.sv
`timescale 1ns/100ps

module multitap_decoder (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::key_code_t key,
  input  logic                  strobe,
  output logic [7:0]            cur_char,
  output logic                  word_done,
  output logic                  game_end,
  axil_if.master                bus
);
  import keypad_pkg::*;
  import bus_pkg::*;

  tap_state_t             state, next_state;
  key_code_t              prev_key; // Last letter key taken
  ptr_t                   wr_ptr; // Next free buffer slot
  logic [7:0]             next_char;
  logic                   aw_pend, w_pend, b_wait;
  logic                   write_busy;
  logic                   press, letter, commit;
  logic [AXIL_ADDR_W-1:0] aw_addr; // Captured slot address

  assign write_busy = aw_pend | w_pend | b_wait;
  assign press      = strobe & ~write_busy & (key != 8'd0); // Drop strobes mid-write
  assign letter     = (letter_base(key) != 8'd0);
  assign commit     = press & (key == submit_letter_key) & (state != IDLE);

  // Tap step for a letter key
  always_comb begin
    next_state = TAP0; // New key or first press
    if (state != IDLE && key == prev_key) begin
      case (state)
        TAP0:    next_state = TAP1;
        TAP1:    next_state = TAP2;
        TAP2:    next_state = four_letter(key) ? TAP3 : TAP0;
        default: next_state = TAP0; // Wrap after TAP3
      endcase
    end
    next_char = letter_base(key) + 8'(next_state) - 8'd1; // Base plus tap index
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state     <= IDLE;
      prev_key  <= '0;
      cur_char  <= '0;
      wr_ptr    <= '0;
      word_done <= 1'b0;
      game_end  <= 1'b0;
      aw_pend   <= 1'b0;
      w_pend    <= 1'b0;
      b_wait    <= 1'b0;
    end else begin
      word_done <= 1'b0;
      // Write channel progress
      if (aw_pend && bus.awready)
        aw_pend <= 1'b0;
      if (w_pend && bus.wready)
        w_pend <= 1'b0;
      if (bus.bvalid && bus.bready)
        b_wait <= 1'b0;

      if (press) begin
        if (letter) begin
          state    <= next_state;
          prev_key <= key;
          cur_char <= next_char;
        end else if (commit) begin
          aw_pend <= 1'b1; // AW and W together
          w_pend  <= 1'b1;
          b_wait  <= 1'b1;
          wr_ptr  <= wr_ptr + 4'd1;
          state   <= IDLE;
        end else if (key == clear_key || key == submit_word_key) begin
          state    <= IDLE;
          cur_char <= '0;
          if (key == submit_word_key) begin
            wr_ptr    <= '0; // Next word from slot 0
            word_done <= 1'b1;
          end
        end else if (key == game_end_key) begin
          game_end <= 1'b1; // Sticky
        end
        // Keys 1, A, B, D fall through
      end
    end
  end

  // Slot address held for the write
  always_ff @(posedge clk) begin
    if (commit)
      aw_addr <= {wr_ptr, 2'b00};
  end

  assign bus.awaddr  = aw_addr;
  assign bus.awvalid = aw_pend;
  assign bus.wdata   = {{(AXIL_DATA_W-8){1'b0}}, cur_char}; // Stable while pending
  assign bus.wvalid  = w_pend;
  assign bus.bready  = b_wait;

  // Never reads
  assign bus.araddr  = '0;
  assign bus.arvalid = 1'b0;
  assign bus.rready  = 1'b0;

  a_aw_stable: assert property (@(posedge clk) disable iff (!nRst)
    bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr))
    else $error("awvalid dropped or awaddr moved before awready");

endmodule

// File: src/word_buffer.sv
`timescale 1ns/100ps

module word_buffer (
  input  logic  clk,
  input  logic  nRst,
  axil_if.slave bus
);
  import bus_pkg::*;

  logic [7:0] mem [BUF_DEPTH]; // One character per word
  logic       wr_go, rd_go;

  // Take AW and W in the same cycle, one response at a time
  assign bus.awready = bus.awvalid & bus.wvalid & ~bus.bvalid;
  assign bus.wready  = bus.awvalid & bus.wvalid & ~bus.bvalid;
  assign bus.arready = ~bus.rvalid;
  assign bus.bresp   = RESP_OKAY;
  assign bus.rresp   = RESP_OKAY;

  assign wr_go = bus.awvalid & bus.awready;
  assign rd_go = bus.arvalid & bus.arready;

  // Response flags
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      bus.bvalid <= 1'b0;
      bus.rvalid <= 1'b0;
    end else begin
      if (wr_go)
        bus.bvalid <= 1'b1;
      else if (bus.bready)
        bus.bvalid <= 1'b0;
      if (rd_go)
        bus.rvalid <= 1'b1;
      else if (bus.rready)
        bus.rvalid <= 1'b0;
    end
  end

  // Storage and read data, lane 0 only
  always_ff @(posedge clk) begin
    if (wr_go)
      mem[bus.awaddr[5:2]] <= bus.wdata[7:0];
    if (rd_go)
      bus.rdata <= {{(AXIL_DATA_W-8){1'b0}}, mem[bus.araddr[5:2]]}; // Zero-extend
  end

endmodule

// File: tb/tb_ref.svh
// LCG step for random key choice
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  lcg_next = s * 32'd1103515245 + 32'd12345;
endfunction

// First letter per key index row*4+col, zero for non-letter keys
function automatic logic [7:0] base_letter(input int idx);
  case (idx)
    1:       base_letter = "A"; // Key 2
    2:       base_letter = "D";
    4:       base_letter = "G";
    5:       base_letter = "J";
    6:       base_letter = "M";
    8:       base_letter = "P"; // Key 7, four letters
    9:       base_letter = "T";
    10:      base_letter = "W"; // Key 9, four letters
    default: base_letter = 8'd0;
  endcase
endfunction

// Multi-tap model, updates ref state and returns the expected word_done pulse
function automatic logic model_press(input int idx);
  logic [7:0] base;
  base = base_letter(idx);
  model_press = 1'b0;
  if (base != 8'd0) begin
    if (ref_taps >= 0 && idx == ref_last)
      ref_taps = (ref_taps + 1) % ((idx == 8 || idx == 10) ? 4 : 3); // Wrap
    else
      ref_taps = 0; // New key starts over
    ref_last = idx;
    ref_char = base + 8'(ref_taps);
  end else if (idx == 12) begin
    if (ref_taps >= 0) begin // Only a letter in progress is written
      ref_buf[ref_ptr]   = ref_char;
      ref_valid[ref_ptr] = 1'b1;
      ref_ptr            = ref_ptr + 4'd1;
    end
    ref_taps = -1;
  end else if (idx == 13 || idx == 14) begin
    ref_taps = -1;
    ref_char = 8'd0;
    if (idx == 14) begin
      ref_ptr     = '0; // Next word from slot 0
      model_press = 1'b1;
    end
  end else if (idx == 11) begin
    ref_game_end = 1'b1;
  end
endfunction

// File: tb/tb_keypad_entry.sv
`timescale 1ns/100ps

module tb_keypad_entry;
  import bus_pkg::*;
  import keypad_pkg::*;

  localparam int SCAN_CLKS    = int'(SCAN_DIV);
  localparam int HOLD_CLKS    = 4 * SCAN_CLKS; // Press and release length
  localparam int PRESS_CLKS   = 14 * SCAN_CLKS; // Column wait plus hold plus release
  localparam int N_DIRECTED   = 37;
  localparam int N_PRESS      = N_DIRECTED + 40;
  localparam int TIMEOUT_CLKS = N_PRESS * PRESS_CLKS * 2;

  logic clk, nRst;
  logic [3:0] row, scan_col;
  logic [7:0] cur_char;
  logic word_done, game_end;
  logic [AXIL_ADDR_W-1:0] awaddr, araddr;
  logic [AXIL_DATA_W-1:0] wdata, rdata;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  resp_t bresp, rresp;

  // Reference state
  int         ref_taps; // -1 while idle
  int         ref_last;
  logic [7:0] ref_char;
  ptr_t       ref_ptr;
  logic [7:0] ref_buf [BUF_DEPTH];
  logic       ref_valid [BUF_DEPTH];
  logic       ref_game_end, ref_done;
  logic       press_ready, done_seen, done_prev;

  ptr_t                   rd_idx [$]; // Host read results
  logic [AXIL_DATA_W-1:0] rd_data [$];
  resp_t                  rd_resp [$];
  event                   press_done, read_done;

  // Key index row*4+col, 12 commit, 13 clear, 14 word, 11 game end
  int directed [N_DIRECTED] = '{1, 2, 4, 5, 6, 8, 9, 10, 12, 1, 1, 1, 1, 12,
                                8, 8, 8, 8, 8, 9, 12, 12, 0, 3, 7, 15, 13,
                                10, 10, 10, 10, 12, 13, 14, 5, 12, 11};

  `include "tb_ref.svh"

  keypad_entry_top i_dut (
    .clk(clk), .nRst(nRst), .row(row), .scan_col(scan_col), .cur_char(cur_char),
    .word_done(word_done), .game_end(game_end),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
    .wvalid(wvalid), .wready(wready), .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata(rdata),
    .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_char(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      stop_run($sformatf("error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_col(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
      stop_run($sformatf("error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [AXIL_DATA_W-1:0] got,
                            input logic [AXIL_DATA_W-1:0] exp);
    if (got !== exp)
      stop_run($sformatf("error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp)
      stop_run($sformatf("error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("error: %s = %h, expected %h", name, got, exp));
  endtask

  // Host read of one slot, result queued for the compare process
  task automatic read_entry(input ptr_t idx);
    @(posedge clk);
    araddr  <= {idx, 2'b00};
    arvalid <= 1'b1;
    rready  <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk); // Arbiter may serve the decoder first
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    rd_idx.push_back(idx);
    rd_data.push_back(rdata);
    rd_resp.push_back(rresp);
    @(posedge clk);
    rready <= 1'b0;
    -> read_done;
  endtask

  // Host write of one slot, bresp checked when it arrives
  task automatic write_entry(input ptr_t idx, input logic [AXIL_DATA_W-1:0] data);
    @(posedge clk);
    awaddr  <= {idx, 2'b00};
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk); // Grant, then AW and W taken together
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    check_resp("bresp", bresp, RESP_OKAY);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  // Keypad model, row held while the key's column is driven
  task automatic press_key(input int idx, input bit overlap);
    logic [3:0] want;
    logic [3:0] prev;
    want = ~(4'b1000 >> (idx % 4));
    prev = want; // Need a fresh column slot
    forever begin
      @(negedge clk);
      if (scan_col == want && prev != want)
        break;
      prev = scan_col;
    end
    @(posedge clk);
    row <= 4'b1000 >> (idx / 4);
    fork
      repeat (HOLD_CLKS) @(posedge clk);
      if (overlap) begin
        repeat (2) @(posedge clk); // arvalid rises with the decoder's awvalid
        read_entry(ptr_t'(0));
      end
    join
    row <= 4'b0000;
    repeat (HOLD_CLKS) @(posedge clk); // Commit done well within release
    @(negedge clk);
  endtask

  // word_done pulse catcher
  initial begin
    done_seen = 1'b0;
    done_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (word_done && done_prev)
        stop_run("word_done stayed high for more than one cycle");
      if (word_done)
        done_seen = 1'b1;
      done_prev = word_done;
    end
  end

  // Compare against the reference
  initial begin
    ptr_t idx_q;
    forever begin
      @(press_done or read_done);
      while (rd_idx.size() > 0) begin
        idx_q = rd_idx.pop_front();
        check_word("rdata", rd_data.pop_front(), {{(AXIL_DATA_W-8){1'b0}}, ref_buf[idx_q]});
        check_resp("rresp", rd_resp.pop_front(), RESP_OKAY);
      end
      if (press_ready) begin
        check_char("cur_char", cur_char, ref_char);
        check_flag("game_end", game_end, ref_game_end);
        check_flag("word_done", done_seen, ref_done);
        done_seen   = 1'b0;
        press_ready = 1'b0;
      end
    end
  end

  // Stimulus
  initial begin
    logic [31:0] rng;
    int          idx;
    bit          overlap;
    ptr_t        wr_slot;
    nRst    = 1'b0;
    row     = 4'b0000;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    ref_taps     = -1;
    ref_last     = -1;
    ref_char     = 8'd0;
    ref_ptr      = '0;
    ref_game_end = 1'b0;
    ref_done     = 1'b0;
    press_ready  = 1'b0;
    for (int i = 0; i < BUF_DEPTH; i++)
      ref_valid[i] = 1'b0;
    rng = 32'd75;
    repeat (2) @(posedge clk);
    nRst <= 1'b1;
    @(negedge clk);
    // Idle outputs straight out of reset
    check_col("scan_col", scan_col, 4'b1111);
    check_flag("word_done", word_done, 1'b0);
    check_flag("game_end", game_end, 1'b0);
    check_flag("bvalid", bvalid, 1'b0);
    check_flag("rvalid", rvalid, 1'b0);
    for (int n = 0; n < N_PRESS; n++) begin
      if (n < N_DIRECTED) begin
        idx = directed[n];
      end else begin
        rng = lcg_next(rng);
        idx = int'(rng[19:16]);
      end
      // Slot 0 read while a later slot commits
      overlap = (idx == 12) && (ref_taps >= 0) && ref_valid[0] && (ref_ptr != 4'd0);
      press_key(idx, overlap);
      ref_done    = model_press(idx);
      press_ready = 1'b1;
      -> press_done;
    end
    // Host write with junk above lane 0, only the low byte is kept
    rng     = lcg_next(rng);
    wr_slot = ptr_t'(rng[19:16]);
    write_entry(wr_slot, rng);
    ref_buf[wr_slot]   = rng[7:0];
    ref_valid[wr_slot] = 1'b1;
    for (int i = 0; i < BUF_DEPTH; i++)
      if (ref_valid[i])
        read_entry(ptr_t'(i));
    @(negedge clk);
    if (rd_idx.size() != 0) begin
      stop_run("host read results were left uncompared");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CLKS) @(posedge clk);
    stop_run("timeout, the key sequence did not finish in time");
  end

endmodule
